// File: sources.f
+incdir+src
src/cavlc_pkg.sv
src/cavlc_block_buffer.sv
src/cavlc_coeff_counter.sv
src/cavlc_trailing_ones.sv
src/cavlc_level_list.sv
src/cavlc_run_list.sv
src/cavlc_stat_top.sv
test/cavlc_stat_sva.sv
test/cavlc_stat_tb.sv

// File: src/cavlc_block_buffer.sv
`timescale 1ns/1ps
`include "cavlc_config.svh"

module cavlc_block_buffer (
    input  logic             clk,
    input  logic             rst,
    input  logic             frame_rst_i,
    input  logic             load_i,
    input  cavlc_pkg::coeff_t coeff_i [0:`CAVLC_BLOCK_N-1],
    input  logic [3:0]       scan_idx_i,
    output cavlc_pkg::coeff_t strm_coeff_o
);

    import cavlc_pkg::*;

    coeff_t     coeff_q [0:`CAVLC_BLOCK_N-1];
    logic [3:0] scan_pos;
    logic [3:0] raster_idx;

    // ----------------------------------------
    // Capture in raster order
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst || frame_rst_i) begin
            for (int i = 0; i < `CAVLC_BLOCK_N; i++) begin
                coeff_q[i] <= '0;
            end
        end else if (load_i) begin
            for (int i = 0; i < `CAVLC_BLOCK_N; i++) begin
                coeff_q[i] <= coeff_i[i];
            end
        end
    end

    // ----------------------------------------
    // Replay in reverse zigzag order
    // ----------------------------------------
    // Highest frequency position comes out first
    assign scan_pos     = 4'd15 - scan_idx_i;
    assign raster_idx   = ZIGZAG_4X4[scan_pos];
    assign strm_coeff_o = coeff_q[raster_idx];

endmodule

// File: src/cavlc_coeff_counter.sv
`timescale 1ns/1ps

module cavlc_coeff_counter (
    input  logic             clk,
    input  logic             rst,
    input  logic             frame_rst_i,
    input  logic             clear_i,
    input  logic             scan_en_i,
    input  cavlc_pkg::coeff_t strm_coeff_i,
    output logic [4:0]       total_coeff_o,
    output logic [4:0]       total_zeros_o
);

    import cavlc_pkg::*;

    logic   nonzero;
    logic   seen_nz;

    assign nonzero    = (strm_coeff_i != '0);

    always_ff @(posedge clk) begin
        if (rst || frame_rst_i || clear_i) begin
            total_coeff_o <= 5'd0;
            total_zeros_o <= 5'd0;
            seen_nz       <= 1'b0;
        end else if (scan_en_i) begin
            if (nonzero) begin
                total_coeff_o <= total_coeff_o + 5'd1;
                seen_nz       <= 1'b1;
            end else if (seen_nz) begin
                // Zeros ahead of the first nonzero lie above the last
                // coefficient in forward order and are not counted
                total_zeros_o <= total_zeros_o + 5'd1;
            end
        end
    end

endmodule

// File: src/cavlc_config.svh
`ifndef CAVLC_CONFIG_SVH
`define CAVLC_CONFIG_SVH

// Quantized coefficient width, signed
`define CAVLC_COEFF_W 8

// Block position coordinate width
`define CAVLC_POS_W 11

// Coefficients per 4x4 block
`define CAVLC_BLOCK_N 16

`endif

// File: src/cavlc_level_list.sv
`timescale 1ns/1ps
`include "cavlc_config.svh"

module cavlc_level_list (
    input  logic             clk,
    input  logic             rst,
    input  logic             frame_rst_i,
    input  logic             clear_i,
    input  logic             scan_en_i,
    input  logic             t1_take_i,
    input  cavlc_pkg::coeff_t strm_coeff_i,
    output cavlc_pkg::coeff_t level_list_o [0:`CAVLC_BLOCK_N-1],
    output logic [4:0]       level_cnt_o
);

    import cavlc_pkg::*;

    coeff_t     level_q [0:`CAVLC_BLOCK_N-1];
    logic       nonzero;
    logic       write_en;
    logic [3:0] wr_idx;

    assign nonzero  = (strm_coeff_i != '0);
    assign write_en = scan_en_i && nonzero && !t1_take_i;
    // Count never reaches 16 before the last write
    assign wr_idx   = level_cnt_o[3:0];

    // ----------------------------------------
    // Level storage
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst || frame_rst_i || clear_i) begin
            for (int i = 0; i < `CAVLC_BLOCK_N; i++) begin
                level_q[i] <= '0;
            end
        end else if (write_en) begin
            level_q[wr_idx] <= strm_coeff_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst || frame_rst_i || clear_i) begin
            level_cnt_o <= 5'd0;
        end else if (write_en) begin
            level_cnt_o <= level_cnt_o + 5'd1;
        end
    end

    assign level_list_o = level_q;

endmodule

// File: src/cavlc_pkg.sv
`include "cavlc_config.svh"

package cavlc_pkg;

    // Controller states
    typedef enum logic [1:0] {
        IDLE = 2'd0,
        LOAD = 2'd1,
        SCAN = 2'd2,
        HOLD = 2'd3
    } cavlc_state_e;

    typedef logic signed [`CAVLC_COEFF_W-1:0] coeff_t;

    // Frame zigzag scan, entry k gives the raster index of scan position k
    parameter logic [3:0] ZIGZAG_4X4 [0:15] = '{
        4'd0, 4'd1, 4'd4, 4'd8, 4'd5, 4'd2, 4'd3, 4'd6,
        4'd9, 4'd12, 4'd13, 4'd10, 4'd7, 4'd11, 4'd14, 4'd15
    };

endpackage

// File: src/cavlc_run_list.sv
`timescale 1ns/1ps
`include "cavlc_config.svh"

module cavlc_run_list (
    input  logic             clk,
    input  logic             rst,
    input  logic             frame_rst_i,
    input  logic             clear_i,
    input  logic             scan_en_i,
    input  cavlc_pkg::coeff_t strm_coeff_i,
    output logic [3:0]       run_list_o [0:`CAVLC_BLOCK_N-1]
);

    import cavlc_pkg::*;

    logic [3:0] run_q [0:`CAVLC_BLOCK_N-1];
    logic [3:0] wr_ptr;
    logic [3:0] open_idx;
    logic       seen_nz;
    logic       nonzero;

    assign nonzero    = (strm_coeff_i != '0);

    // First nonzero opens entry 0, later ones open the next entry
    assign open_idx = seen_nz ? wr_ptr + 4'd1 : wr_ptr;

    // ----------------------------------------
    // Pointer and run entries
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if (rst || frame_rst_i || clear_i) begin
            wr_ptr  <= 4'd0;
            seen_nz <= 1'b0;
            for (int i = 0; i < `CAVLC_BLOCK_N; i++) begin
                run_q[i] <= 4'd0;
            end
        end else if (scan_en_i) begin
            if (nonzero) begin
                run_q[open_idx] <= 4'd0;
                wr_ptr          <= open_idx;
                seen_nz         <= 1'b1;
            end else if (seen_nz) begin
                run_q[wr_ptr] <= run_q[wr_ptr] + 4'd1;
            end
        end
    end

    assign run_list_o = run_q;

endmodule

// File: src/cavlc_stat_top.sv
`timescale 1ns/1ps
`include "cavlc_config.svh"

module cavlc_stat_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    frame_rst_i,
    input  logic                    valid_i,
    input  logic                    enc_ready_i,
    input  logic [`CAVLC_POS_W-1:0] pos_x_i,
    input  logic [`CAVLC_POS_W-1:0] pos_y_i,
    input  cavlc_pkg::coeff_t       coeff_i [0:`CAVLC_BLOCK_N-1],
    output logic                    ready_o,
    output logic                    valid_o,
    output logic [`CAVLC_POS_W-1:0] pos_x_o,
    output logic [`CAVLC_POS_W-1:0] pos_y_o,
    output logic [4:0]              total_coeff_o,
    output logic [4:0]              total_zeros_o,
    output logic [4:0]              level_cnt_o,
    output logic [1:0]              t1_cnt_o,
    output logic [2:0]              t1_sign_o,
    output cavlc_pkg::coeff_t       level_list_o [0:`CAVLC_BLOCK_N-1],
    output logic [3:0]              run_list_o [0:`CAVLC_BLOCK_N-1]
);

    import cavlc_pkg::*;

    localparam logic [3:0] LAST_IDX = 4'(`CAVLC_BLOCK_N - 1);

    cavlc_state_e state;
    cavlc_state_e state_nxt;
    logic [3:0]   scan_idx;
    logic         load;
    logic         scan_en;
    logic         clear;
    logic         t1_take;
    coeff_t       strm_coeff;

    // ----------------------------------------
    // Controller FSM
    // ----------------------------------------
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: if (valid_i) state_nxt = LOAD;
            LOAD: state_nxt = SCAN;
            SCAN: if (scan_idx == LAST_IDX) state_nxt = HOLD;
            HOLD: if (enc_ready_i) state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || frame_rst_i) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    assign load    = (state_nxt == LOAD);
    assign scan_en = (state == SCAN);
    assign clear   = (state_nxt == IDLE);
    assign ready_o = (state == IDLE);
    assign valid_o = (state == HOLD);

    always_ff @(posedge clk) begin
        if (rst || frame_rst_i || load) begin
            scan_idx <= 4'd0;
        end else if (scan_en) begin
            scan_idx <= scan_idx + 4'd1;
        end
    end

    // Block position follows the coefficients through to HOLD
    always_ff @(posedge clk) begin
        if (rst || frame_rst_i) begin
            pos_x_o <= '0;
            pos_y_o <= '0;
        end else if (load) begin
            pos_x_o <= pos_x_i;
            pos_y_o <= pos_y_i;
        end
    end

    // ----------------------------------------
    // Buffer and statistics counters
    // ----------------------------------------
    cavlc_block_buffer i_block_buffer (
        .clk          (clk),
        .rst          (rst),
        .frame_rst_i  (frame_rst_i),
        .load_i       (load),
        .coeff_i      (coeff_i),
        .scan_idx_i   (scan_idx),
        .strm_coeff_o (strm_coeff)
    );

    cavlc_coeff_counter i_coeff_counter (
        .clk           (clk),
        .rst           (rst),
        .frame_rst_i   (frame_rst_i),
        .clear_i       (clear),
        .scan_en_i     (scan_en),
        .strm_coeff_i  (strm_coeff),
        .total_coeff_o (total_coeff_o),
        .total_zeros_o (total_zeros_o)
    );

    cavlc_trailing_ones i_trailing_ones (
        .clk          (clk),
        .rst          (rst),
        .frame_rst_i  (frame_rst_i),
        .clear_i      (clear),
        .scan_en_i    (scan_en),
        .strm_coeff_i (strm_coeff),
        .t1_take_o    (t1_take),
        .t1_cnt_o     (t1_cnt_o),
        .t1_sign_o    (t1_sign_o)
    );

    cavlc_level_list i_level_list (
        .clk          (clk),
        .rst          (rst),
        .frame_rst_i  (frame_rst_i),
        .clear_i      (clear),
        .scan_en_i    (scan_en),
        .t1_take_i    (t1_take),
        .strm_coeff_i (strm_coeff),
        .level_list_o (level_list_o),
        .level_cnt_o  (level_cnt_o)
    );

    cavlc_run_list i_run_list (
        .clk          (clk),
        .rst          (rst),
        .frame_rst_i  (frame_rst_i),
        .clear_i      (clear),
        .scan_en_i    (scan_en),
        .strm_coeff_i (strm_coeff),
        .run_list_o   (run_list_o)
    );

endmodule

// File: src/cavlc_trailing_ones.sv
`timescale 1ns/1ps

module cavlc_trailing_ones (
    input  logic             clk,
    input  logic             rst,
    input  logic             frame_rst_i,
    input  logic             clear_i,
    input  logic             scan_en_i,
    input  cavlc_pkg::coeff_t strm_coeff_i,
    output logic             t1_take_o,
    output logic [1:0]       t1_cnt_o,
    output logic [2:0]       t1_sign_o
);

    import cavlc_pkg::*;

    localparam coeff_t PLUS_ONE  = 1;
    localparam coeff_t MINUS_ONE = -1;

    logic is_pos1;
    logic is_neg1;
    logic nonzero;
    logic open_q;

    assign is_pos1 = (strm_coeff_i == PLUS_ONE);
    assign is_neg1 = (strm_coeff_i == MINUS_ONE);
    assign nonzero = (strm_coeff_i != '0);

    // At most three trailing ones per block
    assign t1_take_o = scan_en_i && open_q && (is_pos1 || is_neg1) && (t1_cnt_o != 2'd3);

    always_ff @(posedge clk) begin
        if (rst || frame_rst_i || clear_i) begin
            open_q    <= 1'b1;
            t1_cnt_o  <= 2'd0;
            t1_sign_o <= 3'b000;
        end else if (t1_take_o) begin
            t1_cnt_o            <= t1_cnt_o + 2'd1;
            t1_sign_o[t1_cnt_o] <= is_neg1;
        end else if (scan_en_i && nonzero) begin
            // Larger level or a fourth +-1 ends the run
            open_q <= 1'b0;
        end
    end

endmodule

// File: test/cavlc_stat_sva.sv
`timescale 1ns/1ps

module cavlc_stat_sva (
    input logic       clk,
    input logic       rst,
    input logic       frame_rst_i,
    input logic       ready_o,
    input logic       valid_o,
    input logic       enc_ready_i,
    input logic [4:0] total_coeff_o,
    input logic [1:0] t1_cnt_o
);

    // IDLE and HOLD are distinct states
    ready_valid_excl: assert property (@(posedge clk) disable iff (rst)
        !(ready_o && valid_o))
        else $error("ready_o and valid_o high in the same cycle");

    // Results stay offered until the entropy coder takes them
    valid_held: assert property (@(posedge clk) disable iff (rst || frame_rst_i)
        (valid_o && !enc_ready_i) |=> valid_o)
        else $error("valid_o dropped without enc_ready_i");

    total_coeff_range: assert property (@(posedge clk) disable iff (rst)
        total_coeff_o <= 5'd16)
        else $error("total_coeff_o above 16");

    t1_within_total: assert property (@(posedge clk) disable iff (rst)
        {3'b000, t1_cnt_o} <= total_coeff_o)
        else $error("t1_cnt_o exceeds total_coeff_o");

endmodule

bind cavlc_stat_top cavlc_stat_sva i_cavlc_stat_sva (.*);

// File: test/cavlc_stat_tb.sv
`timescale 1ns/1ps
`include "cavlc_config.svh"

module cavlc_stat_tb;

    import cavlc_pkg::*;

    localparam int LATENCY     = 17;
    localparam int MAX_DELAY   = 24;
    localparam int N_RANDOM    = 200;
    localparam int N_CORNER    = 6;
    localparam int N_BACKPR    = 20;
    localparam int N_ABORT     = 10;
    localparam int N_BLOCKS    = N_RANDOM + N_CORNER + N_BACKPR + 2 * N_ABORT;
    localparam int WATCHDOG_NS = N_BLOCKS * (18 + MAX_DELAY + 4) * 8 + 4000;

    logic                    clk;
    logic                    rst;
    logic                    frame_rst_i;
    logic                    valid_i;
    logic                    enc_ready_i;
    logic [`CAVLC_POS_W-1:0] pos_x_i;
    logic [`CAVLC_POS_W-1:0] pos_y_i;
    coeff_t                  coeff_i [0:`CAVLC_BLOCK_N-1];
    logic                    ready_o;
    logic                    valid_o;
    logic [`CAVLC_POS_W-1:0] pos_x_o;
    logic [`CAVLC_POS_W-1:0] pos_y_o;
    logic [4:0]              total_coeff_o;
    logic [4:0]              total_zeros_o;
    logic [4:0]              level_cnt_o;
    logic [1:0]              t1_cnt_o;
    logic [2:0]              t1_sign_o;
    coeff_t                  level_list_o [0:`CAVLC_BLOCK_N-1];
    logic [3:0]              run_list_o [0:`CAVLC_BLOCK_N-1];

    // Stimulus and expected results
    coeff_t                  cur_blk [0:`CAVLC_BLOCK_N-1];
    logic [`CAVLC_POS_W-1:0] cur_x;
    logic [`CAVLC_POS_W-1:0] cur_y;
    string                   cur_test;
    string                   exp_test;
    logic [`CAVLC_POS_W-1:0] exp_x;
    logic [`CAVLC_POS_W-1:0] exp_y;
    int                      exp_total_coeff;
    int                      exp_total_zeros;
    int                      exp_t1_cnt;
    logic [2:0]              exp_t1_sign;
    int                      exp_level_cnt;
    coeff_t                  exp_level [0:`CAVLC_BLOCK_N-1];
    int                      exp_run [0:`CAVLC_BLOCK_N-1];

    int cycle;
    int accept_cycle;
    int hold_min;
    int hold_max;
    int blocks_sent;
    int blocks_checked;
    int check_count;
    int error_count;
    int kind;
    int hold_delay;
    bit prev_valid;

    cavlc_stat_top i_cavlc_stat_top (
        .clk           (clk),
        .rst           (rst),
        .frame_rst_i   (frame_rst_i),
        .valid_i       (valid_i),
        .enc_ready_i   (enc_ready_i),
        .pos_x_i       (pos_x_i),
        .pos_y_i       (pos_y_i),
        .coeff_i       (coeff_i),
        .ready_o       (ready_o),
        .valid_o       (valid_o),
        .pos_x_o       (pos_x_o),
        .pos_y_o       (pos_y_o),
        .total_coeff_o (total_coeff_o),
        .total_zeros_o (total_zeros_o),
        .level_cnt_o   (level_cnt_o),
        .t1_cnt_o      (t1_cnt_o),
        .t1_sign_o     (t1_sign_o),
        .level_list_o  (level_list_o),
        .run_list_o    (run_list_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    // ----------------------------------------
    // Reference model
    // ----------------------------------------
    // Walks the block from the highest zigzag position down
    function automatic void ref_block();
        coeff_t c;
        int     k;
        int     ptr;
        int     idx;
        bit     seen;
        bit     t1_open;
        bit     take;
        exp_total_coeff = 0;
        exp_total_zeros = 0;
        exp_t1_cnt      = 0;
        exp_t1_sign     = 3'b000;
        exp_level_cnt   = 0;
        ptr             = 0;
        seen            = 1'b0;
        t1_open         = 1'b1;
        for (k = 0; k < `CAVLC_BLOCK_N; k++) begin
            exp_level[k] = '0;
            exp_run[k]   = 0;
        end
        for (k = 0; k < `CAVLC_BLOCK_N; k++) begin
            c    = cur_blk[ZIGZAG_4X4[15 - k]];
            take = 1'b0;
            if (c != 0) begin
                exp_total_coeff++;
            end else if (seen) begin
                exp_total_zeros++;
            end
            if (t1_open && (c == 1 || c == -1) && exp_t1_cnt < 3) begin
                exp_t1_sign[exp_t1_cnt] = (c < 0);
                exp_t1_cnt++;
                take = 1'b1;
            end else if (c != 0) begin
                t1_open = 1'b0;
            end
            if (c != 0 && !take) begin
                exp_level[exp_level_cnt] = c;
                exp_level_cnt++;
            end
            if (c != 0) begin
                idx          = seen ? ptr + 1 : ptr;
                exp_run[idx] = 0;
                ptr          = idx;
                seen         = 1'b1;
            end else if (seen) begin
                exp_run[ptr]++;
            end
        end
    endfunction

    function automatic coeff_t rand_sign(input int mag);
        if ($urandom_range(1, 0) == 1) begin
            return coeff_t'(-mag);
        end
        return coeff_t'(mag);
    endfunction

    task automatic make_random_block();
        int zero_pct;
        int sel;
        int i;
        zero_pct = $urandom_range(85, 50);
        for (i = 0; i < `CAVLC_BLOCK_N; i++) begin
            sel = $urandom_range(99, 0);
            if (sel < zero_pct) begin
                cur_blk[i] = '0;
            end else begin
                // Small magnitudes dominate quantized residuals
                sel = $urandom_range(9, 0);
                if (sel < 5) cur_blk[i] = rand_sign(1);
                else if (sel < 8) cur_blk[i] = rand_sign(2);
                else cur_blk[i] = rand_sign($urandom_range(127, 3));
            end
        end
        cur_x = `CAVLC_POS_W'($urandom);
        cur_y = `CAVLC_POS_W'($urandom);
    endtask

    task automatic make_corner(input int sel);
        int i;
        for (i = 0; i < `CAVLC_BLOCK_N; i++) begin
            cur_blk[i] = (sel == 3) ? rand_sign(1) : coeff_t'(0);
        end
        case (sel)
            1: cur_blk[$urandom_range(15, 0)] = 1;
            2: cur_blk[$urandom_range(15, 0)] = -1;
            4: begin
                // A +-2 reaches the stream before any +-1
                cur_blk[ZIGZAG_4X4[13]] = rand_sign(2);
                cur_blk[ZIGZAG_4X4[10]] = rand_sign(1);
                cur_blk[ZIGZAG_4X4[7]]  = rand_sign(1);
                cur_blk[ZIGZAG_4X4[3]]  = rand_sign(1);
            end
            5: begin
                for (i = 12; i < 16; i++) begin
                    cur_blk[ZIGZAG_4X4[i]] = rand_sign(1);
                end
                cur_blk[0] = 5;
            end
            default: ;
        endcase
        cur_x = `CAVLC_POS_W'($urandom);
        cur_y = `CAVLC_POS_W'($urandom);
    endtask

    task automatic drive_inputs();
        int i;
        pos_x_i <= cur_x;
        pos_y_i <= cur_y;
        for (i = 0; i < `CAVLC_BLOCK_N; i++) begin
            coeff_i[i] <= cur_blk[i];
        end
    endtask

    task automatic send_block();
        @(posedge clk);
        valid_i <= 1'b1;
        drive_inputs();
        do begin
            @(negedge clk);
        end while (!ready_o);
        // The next rising edge accepts this block
        ref_block();
        exp_x        = cur_x;
        exp_y        = cur_y;
        exp_test     = cur_test;
        accept_cycle = cycle + 1;
        @(posedge clk);
        valid_i <= 1'b0;
    endtask

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic check_value(input string what, input int expv, input int actv);
        check_count++;
        assert (actv == expv)
        else begin
            error_count++;
            $display("ERROR %s %s (block %0d): expected %0d, actual %0d",
                     exp_test, what, blocks_checked, expv, actv);
        end
    endtask

    task automatic check_true(input bit cond, input string msg);
        check_count++;
        assert (cond)
        else begin
            error_count++;
            $display("Failure in %s: %s", exp_test, msg);
        end
    endtask

    task automatic compare_results();
        int i;
        check_value("pos_x", int'(exp_x), int'(pos_x_o));
        check_value("pos_y", int'(exp_y), int'(pos_y_o));
        check_value("total_coeff", exp_total_coeff, int'(total_coeff_o));
        check_value("total_zeros", exp_total_zeros, int'(total_zeros_o));
        check_value("t1_cnt", exp_t1_cnt, int'(t1_cnt_o));
        check_value("t1_sign", int'(exp_t1_sign), int'(t1_sign_o));
        check_value("level_cnt", exp_level_cnt, int'(level_cnt_o));
        for (i = 0; i < `CAVLC_BLOCK_N; i++) begin
            check_value($sformatf("level_list[%0d]", i), int'(exp_level[i]),
                        int'(level_list_o[i]));
            check_value($sformatf("run_list[%0d]", i), exp_run[i], int'(run_list_o[i]));
        end
        check_true(!ready_o, "ready_o high while results are held");
    endtask

    task automatic print_summary();
        $display("Summary: %0d blocks checked, %0d checks, %0d errors",
                 blocks_checked, check_count, error_count);
    endtask

    // Results are compared on every HOLD cycle, so back-pressure is covered too
    initial begin
        prev_valid = 1'b0;
        forever begin
            @(negedge clk);
            if (valid_o) begin
                if (!prev_valid) begin
                    blocks_checked++;
                    check_value("valid_o cycle", accept_cycle + LATENCY, cycle);
                end
                compare_results();
            end
            prev_valid = valid_o;
        end
    end

    // Entropy coder stand-in
    initial begin
        forever begin
            @(negedge clk);
            if (valid_o) begin
                hold_delay = $urandom_range(hold_max, hold_min);
                repeat (hold_delay) @(posedge clk);
                @(posedge clk);
                enc_ready_i <= 1'b1;
                @(posedge clk);
                enc_ready_i <= 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        print_summary();
        $display("TEST FAIL");
        $finish;
    end

    // ----------------------------------------
    // Test sequence
    // ----------------------------------------
    initial begin
        void'($urandom(32'h66ae5bbe));
        rst         = 1'b1;
        frame_rst_i = 1'b0;
        valid_i     = 1'b0;
        enc_ready_i = 1'b0;
        pos_x_i     = '0;
        pos_y_i     = '0;
        for (int i = 0; i < `CAVLC_BLOCK_N; i++) begin
            coeff_i[i] = '0;
        end
        cycle          = 0;
        blocks_sent    = 0;
        blocks_checked = 0;
        check_count    = 0;
        error_count    = 0;
        hold_min       = 0;
        hold_max       = 4;
        repeat (4) @(posedge clk);
        rst <= 1'b0;

        cur_test = "random";
        repeat (N_RANDOM) begin
            make_random_block();
            send_block();
            blocks_sent++;
        end

        cur_test = "corner";
        for (kind = 0; kind < N_CORNER; kind++) begin
            make_corner(kind);
            send_block();
            blocks_sent++;
        end

        cur_test = "back-pressure";
        hold_min = 6;
        hold_max = MAX_DELAY;
        repeat (N_BACKPR) begin
            make_random_block();
            send_block();
            blocks_sent++;
            do begin
                @(negedge clk);
            end while (!valid_o);
            // Offer another block while the results are held
            make_random_block();
            @(posedge clk);
            valid_i <= 1'b1;
            drive_inputs();
            repeat (3) @(posedge clk);
            valid_i <= 1'b0;
            @(negedge clk);
            check_true(valid_o && !ready_o, "a block was accepted while results were held");
        end

        cur_test = "frame reset";
        hold_min = 0;
        hold_max = 4;
        repeat (N_ABORT) begin
            make_random_block();
            send_block();
            repeat ($urandom_range(15, 1)) @(posedge clk);
            frame_rst_i <= 1'b1;
            @(posedge clk);
            frame_rst_i <= 1'b0;
            @(negedge clk);
            check_true(ready_o && !valid_o, "controller not idle after frame reset");
            check_value("total_coeff after reset", 0, int'(total_coeff_o));
            check_value("level_cnt after reset", 0, int'(level_cnt_o));
            make_random_block();
            send_block();
            blocks_sent++;
        end

        do begin
            @(negedge clk);
        end while (!ready_o);
        repeat (2) @(negedge clk);
        check_value("result blocks", blocks_sent, blocks_checked);
        print_summary();
        if (error_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule
